// File: src/decode_settings.svh
//------------------------------------------------------------
// Width settings for the decode stage RTL and its testbench
// Include this wherever a DEC_ macro is used
//------------------------------------------------------------
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Instruction, rm0 and register value width
`define DEC_WORD_WIDTH 32

// Architectural registers, x0 included
`define DEC_REG_COUNT 32

// Bits needed to name one register
`define DEC_REG_IDX_WIDTH 5

// Raw offset as gathered from the instruction fields
`define DEC_OFFSET_WIDTH 12

`endif

// File: src/decode_pkg.sv
//------------------------------------------------------------
// Types and opcode values for the decode stage
// Modules import it; stage bundles are built from these structs
//------------------------------------------------------------
`include "decode_settings.svh"

package decode_pkg;

  // Basic scalar types
  typedef logic [`DEC_WORD_WIDTH-1:0]    word_t;
  typedef logic [`DEC_REG_IDX_WIDTH-1:0] reg_idx_t;
  typedef logic [`DEC_OFFSET_WIDTH-1:0]  offset_t;
  typedef logic [6:0]                    opcode_t;

  // Major opcodes that the control unit knows
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // Control word handed to execute, 9 bits
  typedef struct packed {
    logic       branch;
    logic       reg_write;
    logic       mem_read;
    logic       mem_to_reg;
    logic [1:0] alu_op;
    logic       mem_write;
    logic       alu_src;
    logic       is_imm;
  } ctrl_t;

  // Source values plus the three register indices
  typedef struct packed {
    word_t    rs1_value;
    word_t    rs2_value;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
  } operands_t;

  // Held by the fetch/decode register
  typedef struct packed {
    word_t rm0;
    word_t instruction;
  } fetch_bundle_t;

  // Everything execute needs, held by the decode/execute register
  typedef struct packed {
    word_t     rm0;
    word_t     instruction;
    ctrl_t     ctrl;
    operands_t operands;
    offset_t   offset;
  } decode_bundle_t;

endpackage

// File: src/control_unit.sv
//------------------------------------------------------------
// Combinational instruction decoder
// Gives the control word, the raw offset and the register fields
//------------------------------------------------------------
`include "decode_settings.svh"

module control_unit (
  input  decode_pkg::word_t    instruction,
  output decode_pkg::ctrl_t    ctrl,
  output decode_pkg::offset_t  offset,
  output decode_pkg::reg_idx_t rs1_idx,
  output decode_pkg::reg_idx_t rs2_idx,
  output decode_pkg::reg_idx_t rd_idx
);

  import decode_pkg::*;

  opcode_t opcode;

  assign opcode = instruction[6:0];

  // Register fields sit at fixed positions for every format
  assign rd_idx  = instruction[11:7];
  assign rs1_idx = instruction[19:15];
  assign rs2_idx = instruction[24:20];

  // Control word per opcode
  always_comb
  begin
    // Unknown opcodes leave everything off
    ctrl = '0;
    case (opcode)
      OPC_OP:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = 2'b10;
      end
      OPC_OP_IMM:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.is_imm    = 1'b1;
        ctrl.alu_op    = 2'b10;
      end
      OPC_LOAD:
      begin
        // Address add, result comes back from memory
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.alu_op     = 2'b00;
      end
      OPC_STORE:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = 2'b00;
      end
      OPC_BRANCH:
      begin
        // Compare through the ALU subtract path
        ctrl.branch = 1'b1;
        ctrl.alu_op = 2'b01;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

  // Offset gathered per format, not sign extended here
  always_comb
  begin
    case (opcode)
      OPC_OP_IMM, OPC_LOAD:
        offset = instruction[31:20];
      OPC_STORE:
        offset = {instruction[31:25], instruction[11:7]};
      // B-type order, bit 31 then 7, 30:25, 11:8
      OPC_BRANCH:
        offset = {instruction[31], instruction[7], instruction[30:25], instruction[11:8]};
      default:
        offset = '0;
    endcase
  end

  // A load and a store in one word would hit memory twice
  always_comb
  begin
    a_mem_excl: assert (!(ctrl.mem_read && ctrl.mem_write))
      else $error("control_unit: mem_read and mem_write both set for %h", instruction);
  end

endmodule

// File: src/register_file.sv
//------------------------------------------------------------
// Register file with two read ports and one write-back port
// x0 reads zero; a same-cycle write is bypassed to the reads
//------------------------------------------------------------
`include "decode_settings.svh"

module register_file (
  input  logic                 clk,
  input  logic                 arst_n,
  input  decode_pkg::reg_idx_t rs1_idx,
  input  decode_pkg::reg_idx_t rs2_idx,
  output decode_pkg::word_t    rs1_value,
  output decode_pkg::word_t    rs2_value,
  input  logic                 wb_en,
  input  decode_pkg::reg_idx_t wb_addr,
  input  decode_pkg::word_t    wb_data
);

  import decode_pkg::*;

  // Entry 0 is never written, only 1..31 take write-backs
  word_t regs [`DEC_REG_COUNT];

  logic wb_live;

  // Write-back that actually lands in the array
  assign wb_live = wb_en && (wb_addr != '0);

  // Write port runs every edge, stall has no say here
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `DEC_REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb_live)
    begin
      regs[wb_addr] <= wb_data;
    end
  end

  // One read port, used twice below
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0)
    begin
      return '0;
    end
    // Value being written this cycle wins over the stored one
    else if (wb_live && (wb_addr == idx))
    begin
      return wb_data;
    end
    else
    begin
      return regs[idx];
    end
  endfunction

  always_comb
  begin
    rs1_value = read_port(rs1_idx);
  end

  always_comb
  begin
    rs2_value = read_port(rs2_idx);
  end

  // Storage behind x0 must stay zero over any write sequence
  a_x0_kept: assert property (@(posedge clk) disable iff (!arst_n)
    regs[0] == '0)
    else $error("register_file: entry 0 changed to %h", regs[0]);

endmodule

// File: src/stage_register.sv
//------------------------------------------------------------
// Pipeline register for any packed payload
// Loads when load is high, holds otherwise, clears on reset
//------------------------------------------------------------

module stage_register #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  // Zero payload after reset gives an all-zero control word downstream
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      q <= '0;
    end
    else if (load)
    begin
      q <= d;
    end
  end

  // Back-pressure must freeze the whole payload
  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !load |=> $stable(q))
    else $error("stage_register: payload moved without load");

endmodule

// File: src/decode_stage.sv
//------------------------------------------------------------
// Decode stage top level
// Fetch register, decoder and register file feed the execute register
//------------------------------------------------------------
`include "decode_settings.svh"

module decode_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  decode_pkg::word_t          rm0_in,
  input  decode_pkg::word_t          instruction_in,
  input  logic                       stall,
  input  logic                       alu_op_done,
  input  logic                       wb_en,
  input  decode_pkg::reg_idx_t       wb_addr,
  input  decode_pkg::word_t          wb_data,
  output decode_pkg::decode_bundle_t decode_out
);

  import decode_pkg::*;

  logic           advance;
  fetch_bundle_t  fetch_d;
  fetch_bundle_t  fetch_q;
  ctrl_t          ctrl;
  offset_t        offset;
  operands_t      operands;
  decode_bundle_t decode_d;

  // Both registers move together, only with no stall and the ALU done
  assign advance = !stall && alu_op_done;

  assign fetch_d.rm0         = rm0_in;
  assign fetch_d.instruction = instruction_in;

  // Fetch/decode register
  stage_register #(
    .payload_t (fetch_bundle_t)
  ) u_fetch_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (advance),
    .d      (fetch_d),
    .q      (fetch_q)
  );

  // Decoder and register read work side by side on the held word
  control_unit u_control_unit (
    .instruction (fetch_q.instruction),
    .ctrl        (ctrl),
    .offset      (offset),
    .rs1_idx     (operands.rs1_idx),
    .rs2_idx     (operands.rs2_idx),
    .rd_idx      (operands.rd_idx)
  );

  register_file u_register_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rs1_idx   (operands.rs1_idx),
    .rs2_idx   (operands.rs2_idx),
    .rs1_value (operands.rs1_value),
    .rs2_value (operands.rs2_value),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  // Bundle for execute
  assign decode_d.rm0         = fetch_q.rm0;
  assign decode_d.instruction = fetch_q.instruction;
  assign decode_d.ctrl        = ctrl;
  assign decode_d.operands    = operands;
  assign decode_d.offset      = offset;

  // Decode/execute register
  stage_register #(
    .payload_t (decode_bundle_t)
  ) u_execute_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (advance),
    .d      (decode_d),
    .q      (decode_out)
  );

endmodule

// File: dv/decode_model.svh
//------------------------------------------------------------
// Reference model of the decode stage for the testbench
// Include inside the testbench module after importing decode_pkg
//------------------------------------------------------------
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Shadow state, stepped once per rising edge
word_t          shadow_regs [`DEC_REG_COUNT];
fetch_bundle_t  slot_fetch;
decode_bundle_t slot_exec;

// Control word straight from the opcode table
function automatic ctrl_t decode_ctrl(input word_t instr);
  ctrl_t c;
  c = '0;
  case (instr[6:0])
    OPC_OP:
      c = '{branch: 1'b0, reg_write: 1'b1, mem_read: 1'b0, mem_to_reg: 1'b0,
            alu_op: 2'b10, mem_write: 1'b0, alu_src: 1'b0, is_imm: 1'b0};
    OPC_OP_IMM:
      c = '{branch: 1'b0, reg_write: 1'b1, mem_read: 1'b0, mem_to_reg: 1'b0,
            alu_op: 2'b10, mem_write: 1'b0, alu_src: 1'b1, is_imm: 1'b1};
    OPC_LOAD:
      c = '{branch: 1'b0, reg_write: 1'b1, mem_read: 1'b1, mem_to_reg: 1'b1,
            alu_op: 2'b00, mem_write: 1'b0, alu_src: 1'b1, is_imm: 1'b0};
    OPC_STORE:
      c = '{branch: 1'b0, reg_write: 1'b0, mem_read: 1'b0, mem_to_reg: 1'b0,
            alu_op: 2'b00, mem_write: 1'b1, alu_src: 1'b1, is_imm: 1'b0};
    OPC_BRANCH:
      c = '{branch: 1'b1, reg_write: 1'b0, mem_read: 1'b0, mem_to_reg: 1'b0,
            alu_op: 2'b01, mem_write: 1'b0, alu_src: 1'b0, is_imm: 1'b0};
    default:
      c = '0;
  endcase
  return c;
endfunction

// Offset bits per instruction format
function automatic offset_t gather_offset(input word_t instr);
  if ((instr[6:0] == OPC_OP_IMM) || (instr[6:0] == OPC_LOAD))
    return instr[31:20];
  else if (instr[6:0] == OPC_STORE)
    return {instr[31:25], instr[11:7]};
  else if (instr[6:0] == OPC_BRANCH)
    return {instr[31], instr[7], instr[30:25], instr[11:8]};
  return '0;
endfunction

// x0 first, then the write of this cycle, then the shadow array
function automatic word_t read_shadow(input reg_idx_t idx, input logic en,
                                      input reg_idx_t addr, input word_t data);
  if (idx == '0)
    return '0;
  if (en && (addr == idx))
    return data;
  return shadow_regs[idx];
endfunction

function automatic decode_bundle_t build_bundle(input fetch_bundle_t f, input logic en,
                                                input reg_idx_t addr, input word_t data);
  decode_bundle_t b;
  b.rm0                = f.rm0;
  b.instruction        = f.instruction;
  b.ctrl               = decode_ctrl(f.instruction);
  b.offset             = gather_offset(f.instruction);
  b.operands.rd_idx    = f.instruction[11:7];
  b.operands.rs1_idx   = f.instruction[19:15];
  b.operands.rs2_idx   = f.instruction[24:20];
  b.operands.rs1_value = read_shadow(b.operands.rs1_idx, en, addr, data);
  b.operands.rs2_value = read_shadow(b.operands.rs2_idx, en, addr, data);
  return b;
endfunction

task automatic clear_model();
  for (int i = 0; i < `DEC_REG_COUNT; i++)
  begin
    shadow_regs[i] = '0;
  end
  slot_fetch = '0;
  slot_exec  = '0;
endtask

// One rising edge: pipeline slots first, then the write-back lands
task automatic step_model(input logic adv, input word_t rm0, input word_t instr,
                          input logic en, input reg_idx_t addr, input word_t data);
  if (adv)
  begin
    slot_exec              = build_bundle(slot_fetch, en, addr, data);
    slot_fetch.rm0         = rm0;
    slot_fetch.instruction = instr;
  end
  if (en && (addr != '0))
  begin
    shadow_regs[addr] = data;
  end
endtask

`endif

// File: dv/decode_stage_tb.sv
//------------------------------------------------------------
// Testbench for the decode stage
// LFSR stimulus each edge, decode_out checked against the model
//------------------------------------------------------------
`include "decode_settings.svh"

module decode_stage_tb;

  import decode_pkg::*;

  localparam int ADVANCE_TARGET = 2000;
  localparam int CYCLE_LIMIT    = 20000;

  logic           clk;
  logic           arst_n;
  word_t          rm0_in;
  word_t          instruction_in;
  logic           stall;
  logic           alu_op_done;
  logic           wb_en;
  reg_idx_t       wb_addr;
  word_t          wb_data;
  decode_bundle_t decode_out;

  logic [31:0]    lfsr_state;
  int             advances;
  int             cycles;
  logic           last_adv;
  decode_bundle_t prev_out;

  `include "decode_model.svh"

  decode_stage DUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .rm0_in         (rm0_in),
    .instruction_in (instruction_in),
    .stall          (stall),
    .alu_op_done    (alu_op_done),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .decode_out     (decode_out)
  );

  always #10 clk = ~clk;

  // Galois step, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // n fresh bits, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      r          = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Five known opcodes, three of eight picks give a random 7-bit code
  function automatic word_t random_instruction();
    logic [31:0] r;
    logic [6:0]  opc;
    r = random_bits(3);
    case (r[2:0])
      3'd0: opc = OPC_OP;
      3'd1: opc = OPC_OP_IMM;
      3'd2: opc = OPC_LOAD;
      3'd3: opc = OPC_STORE;
      3'd4: opc = OPC_BRANCH;
      default:
      begin
        r   = random_bits(7);
        opc = r[6:0];
      end
    endcase
    r = random_bits(25);
    return {r[24:0], opc};
  endfunction

  // Stall high one time in four, ALU done three times in four
  task automatic drive_stimulus();
    logic [31:0] r;
    rm0_in         <= random_bits(32);
    instruction_in <= random_instruction();
    r = random_bits(2);
    stall <= (r[1:0] == 2'b00);
    r = random_bits(2);
    alu_op_done <= (r[1:0] != 2'b00);
    r = random_bits(1);
    wb_en <= r[0];
    r = random_bits(5);
    wb_addr <= r[4:0];
    wb_data <= random_bits(32);
  endtask

  task automatic report_mismatch(input string name, input string expected, input string actual);
    $display("** Error: %s expected %s got %s", name, expected, actual);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_outputs();
    // Nothing real reaches execute before two advances
    if (advances < 2)
    begin
      assert (decode_out === '0)
        else report_mismatch("decode_out", "0", $sformatf("%h", decode_out));
    end
    // Back-pressure freezes the whole bundle
    if (!last_adv)
    begin
      assert (decode_out === prev_out)
        else report_mismatch("decode_out held", $sformatf("%h", prev_out),
                             $sformatf("%h", decode_out));
    end
    assert (decode_out.rm0 === slot_exec.rm0)
      else report_mismatch("decode_out.rm0", $sformatf("%h", slot_exec.rm0),
                           $sformatf("%h", decode_out.rm0));
    assert (decode_out.instruction === slot_exec.instruction)
      else report_mismatch("decode_out.instruction", $sformatf("%h", slot_exec.instruction),
                           $sformatf("%h", decode_out.instruction));
    assert (decode_out.ctrl === slot_exec.ctrl)
      else report_mismatch("decode_out.ctrl", $sformatf("%h", slot_exec.ctrl),
                           $sformatf("%h", decode_out.ctrl));
    assert (decode_out.offset === slot_exec.offset)
      else report_mismatch("decode_out.offset", $sformatf("%h", slot_exec.offset),
                           $sformatf("%h", decode_out.offset));
    assert (decode_out.operands.rs1_idx === slot_exec.operands.rs1_idx)
      else report_mismatch("decode_out.operands.rs1_idx",
                           $sformatf("%h", slot_exec.operands.rs1_idx),
                           $sformatf("%h", decode_out.operands.rs1_idx));
    assert (decode_out.operands.rs2_idx === slot_exec.operands.rs2_idx)
      else report_mismatch("decode_out.operands.rs2_idx",
                           $sformatf("%h", slot_exec.operands.rs2_idx),
                           $sformatf("%h", decode_out.operands.rs2_idx));
    assert (decode_out.operands.rd_idx === slot_exec.operands.rd_idx)
      else report_mismatch("decode_out.operands.rd_idx",
                           $sformatf("%h", slot_exec.operands.rd_idx),
                           $sformatf("%h", decode_out.operands.rd_idx));
    assert (decode_out.operands.rs1_value === slot_exec.operands.rs1_value)
      else report_mismatch("decode_out.operands.rs1_value",
                           $sformatf("%h", slot_exec.operands.rs1_value),
                           $sformatf("%h", decode_out.operands.rs1_value));
    assert (decode_out.operands.rs2_value === slot_exec.operands.rs2_value)
      else report_mismatch("decode_out.operands.rs2_value",
                           $sformatf("%h", slot_exec.operands.rs2_value),
                           $sformatf("%h", decode_out.operands.rs2_value));
    // Model bundle of this edge, what a held output must still show next edge
    prev_out = slot_exec;
  endtask

  initial
  begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    rm0_in         = '0;
    instruction_in = '0;
    stall          = 1'b0;
    alu_op_done    = 1'b0;
    wb_en          = 1'b0;
    wb_addr        = '0;
    wb_data        = '0;
    lfsr_state     = 32'he1d1;
    advances       = 0;
    cycles         = 0;
    last_adv       = 1'b0;
    prev_out       = '0;
    clear_model();
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    while ((advances < ADVANCE_TARGET) && (cycles < CYCLE_LIMIT))
    begin
      @(posedge clk);
      // Inputs at this edge were driven one edge earlier
      last_adv = !stall && alu_op_done;
      step_model(last_adv, rm0_in, instruction_in, wb_en, wb_addr, wb_data);
      if (last_adv)
        advances++;
      drive_stimulus();
      @(negedge clk);
      check_outputs();
      cycles++;
    end
    if (advances < ADVANCE_TARGET)
    begin
      $display("Timeout: only %0d of %0d advances within %0d cycles",
               advances, ADVANCE_TARGET, CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $fatal(1, "advance count not reached");
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: decode_stage.f
+incdir+src
+incdir+dv
src/decode_pkg.sv
src/control_unit.sv
src/register_file.sv
src/stage_register.sv
src/decode_stage.sv
dv/decode_stage_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -j 0 --top-module decode_stage_tb \
		-f decode_stage.f -Mdir obj_dir
	-./obj_dir/Vdecode_stage_tb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) && echo "test passed" || \
		(echo "test failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
